// File: src/l2_cache_pkg.sv
// L2 cache package.
// Geometry, address split, mux selects and the control/status bundles
// shared by the control block and the datapath.

package l2_cache_pkg;

    ////////////////////
    // geometry
    ////////////////////
    localparam int num_ways = 4;
    localparam int num_sets = 8;
    localparam int s_offset = 5;
    localparam int s_index  = 3;
    localparam int s_tag    = 32 - s_offset - s_index;

    typedef logic [255:0]         line_t;
    typedef logic [s_tag-1:0]     tag_t;
    typedef logic [num_ways-1:0]  way_vec_t;
    typedef logic [2:0]           plru_t;     // bit 0 picks the half, bits 1 and 2 the way.

    typedef struct packed {
        tag_t tag;
        logic valid;
        logic dirty;
    } tag_entry_t;

    typedef struct packed {
        tag_t                tag;
        logic [s_index-1:0]  index;
        logic [s_offset-1:0] offset;
    } addr_fields_t;

    ////////////////////
    // mux selects
    ////////////////////
    typedef enum logic {
        data_in_cpu,
        data_in_mem
    } data_in_sel_t;

    typedef enum logic {
        pmem_addr_fill,
        pmem_addr_wb
    } pmem_addr_sel_t;

    typedef struct packed {
        way_vec_t       tag_load;
        way_vec_t       data_load;
        logic           valid_in;
        logic           dirty_in;
        data_in_sel_t   data_in_sel;
        pmem_addr_sel_t pmem_addr_sel;
        logic [1:0]     victim_way;
        logic [1:0]     out_way;
    } dp_ctrl_t;

    typedef struct packed {
        way_vec_t   hit;
        logic [1:0] hit_way;
        way_vec_t   valid;
        way_vec_t   dirty;
    } dp_status_t;

endpackage

// File: src/l2_set_array.sv
// Storage array for one cache way.
// Synchronous write, registered read, write-first on a same-index
// write. Serves both the tag entries and the data lines.

module l2_set_array #(
    parameter type payload_t = logic,
    parameter int  depth     = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [l2_cache_pkg::s_index-1:0] index,
    input  logic                             load,
    input  payload_t                         datain,
    output payload_t                         dataout
);

    ////////////////////
    // storage
    ////////////////////
    payload_t mem [depth];

    // the index comes straight from the live request address, so the read
    // data settles one edge after the address does.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;    // clears every valid and dirty bit.
            end
            dataout <= '0;
        end else begin
            if (load) begin
                mem[index] <= datain;
                dataout    <= datain;    // new value wins over the old entry.
            end else begin
                dataout    <= mem[index];
            end
        end
    end

endmodule

// File: src/l2_cache_datapath.sv
// L2 cache datapath.
// Four tag ways and four data ways, hit detection, the fill and
// write data muxes and the physical address mux.

module l2_cache_datapath (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [31:0]              mem_address,
    input  l2_cache_pkg::line_t      mem_wdata256,
    output l2_cache_pkg::line_t      mem_rdata256,
    input  l2_cache_pkg::line_t      pmem_rdata,
    output l2_cache_pkg::line_t      pmem_wdata,
    output logic [31:0]              pmem_address,
    input  l2_cache_pkg::dp_ctrl_t   ctrl,
    output l2_cache_pkg::dp_status_t status
);

    l2_cache_pkg::addr_fields_t addr;
    l2_cache_pkg::tag_entry_t   tag_in;
    l2_cache_pkg::line_t        line_in;
    l2_cache_pkg::tag_entry_t   tag_out  [l2_cache_pkg::num_ways];
    l2_cache_pkg::line_t        data_out [l2_cache_pkg::num_ways];
    l2_cache_pkg::way_vec_t     hit_vec;
    logic [1:0]                 hit_way;

    assign addr = l2_cache_pkg::addr_fields_t'(mem_address);

    ////////////////////
    // write data
    ////////////////////
    // every write replaces the whole line and takes its tag from the request.
    assign tag_in.tag   = addr.tag;
    assign tag_in.valid = ctrl.valid_in;
    assign tag_in.dirty = ctrl.dirty_in;

    always_comb begin
        case (ctrl.data_in_sel)
            l2_cache_pkg::data_in_mem: line_in = pmem_rdata;    // line fill.
            default:                   line_in = mem_wdata256;  // cpu write.
        endcase
    end

    ////////////////////
    // arrays
    ////////////////////
    for (genvar w = 0; w < l2_cache_pkg::num_ways; w++) begin : g_way
        l2_set_array #(
            .payload_t (l2_cache_pkg::tag_entry_t),
            .depth     (l2_cache_pkg::num_sets)
        ) tag_array_i (
            .clk     (clk),
            .rst_n   (rst_n),
            .index   (addr.index),
            .load    (ctrl.tag_load[w]),
            .datain  (tag_in),
            .dataout (tag_out[w])
        );

        l2_set_array #(
            .payload_t (l2_cache_pkg::line_t),
            .depth     (l2_cache_pkg::num_sets)
        ) data_array_i (
            .clk     (clk),
            .rst_n   (rst_n),
            .index   (addr.index),
            .load    (ctrl.data_load[w]),
            .datain  (line_in),
            .dataout (data_out[w])
        );

        assign status.valid[w] = tag_out[w].valid;
        assign status.dirty[w] = tag_out[w].dirty;
        assign hit_vec[w]      = tag_out[w].valid && (tag_out[w].tag == addr.tag);
    end

    ////////////////////
    // hit way
    ////////////////////
    // at most one way matches, so a plain priority scan is an encoder.
    always_comb begin
        hit_way = 2'd0;
        for (int w = 0; w < l2_cache_pkg::num_ways; w++) begin
            if (hit_vec[w]) begin
                hit_way = 2'(w);
            end
        end
    end

    assign status.hit     = hit_vec;
    assign status.hit_way = hit_way;

    ////////////////////
    // outputs
    ////////////////////
    assign mem_rdata256 = data_out[ctrl.out_way];
    assign pmem_wdata   = data_out[ctrl.victim_way];    // victim line for writeback.

    always_comb begin
        case (ctrl.pmem_addr_sel)
            l2_cache_pkg::pmem_addr_wb:
                pmem_address = {tag_out[ctrl.victim_way].tag, addr.index,
                                {l2_cache_pkg::s_offset{1'b0}}};
            default:
                pmem_address = {addr.tag, addr.index, {l2_cache_pkg::s_offset{1'b0}}};
        endcase
    end

endmodule

// File: src/l2_cache_control.sv
// L2 cache controller.
// Lookup, miss, writeback and fill FSM, the per-set pseudo-LRU
// state and the handshakes on both sides.

module l2_cache_control (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [31:0]              mem_address,
    input  logic                     mem_read,
    input  logic                     mem_write,
    output logic                     mem_resp,
    output logic                     pmem_read,
    output logic                     pmem_write,
    input  logic                     pmem_resp,
    input  l2_cache_pkg::dp_status_t status,
    output l2_cache_pkg::dp_ctrl_t   ctrl
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_compare,
        st_respond,
        st_writeback,
        st_fill
    } state_t;

    state_t                     state, state_next;
    l2_cache_pkg::addr_fields_t addr;
    l2_cache_pkg::plru_t        plru_q [l2_cache_pkg::num_sets];
    l2_cache_pkg::plru_t        plru_cur;
    logic [1:0]                 victim_c;
    logic [1:0]                 victim_q;
    logic                       hit_any;

    ////////////////////
    // pseudo-LRU
    ////////////////////
    // points every bit on the path of the used way away from it.
    function automatic l2_cache_pkg::plru_t plru_touch(l2_cache_pkg::plru_t cur,
                                                       logic [1:0] way);
        l2_cache_pkg::plru_t nxt;
        nxt    = cur;
        nxt[0] = ~way[1];
        if (way[1]) begin
            nxt[2] = ~way[0];
        end else begin
            nxt[1] = ~way[0];
        end
        return nxt;
    endfunction

    assign addr     = l2_cache_pkg::addr_fields_t'(mem_address);
    assign plru_cur = plru_q[addr.index];
    assign hit_any  = |status.hit;

    // an invalid way is taken first and the tree only decides among full sets.
    always_comb begin
        victim_c = plru_cur[0] ? {1'b1, plru_cur[2]} : {1'b0, plru_cur[1]};
        for (int w = l2_cache_pkg::num_ways - 1; w >= 0; w--) begin
            if (!status.valid[w]) begin
                victim_c = 2'(w);
            end
        end
    end

    ////////////////////
    // state
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            victim_q <= 2'd0;
            for (int s = 0; s < l2_cache_pkg::num_sets; s++) begin
                plru_q[s] <= '0;
            end
        end else begin
            state <= state_next;
            if (state == st_compare) begin
                victim_q <= victim_c;    // held through writeback and fill.
            end
            if (state == st_compare && hit_any) begin
                plru_q[addr.index] <= plru_touch(plru_cur, status.hit_way);
            end else if (state == st_fill && pmem_resp) begin
                plru_q[addr.index] <= plru_touch(plru_cur, victim_q);
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle:      if (mem_read || mem_write) state_next = st_lookup;
            st_lookup:    state_next = st_compare;
            st_compare: begin
                if (hit_any) begin
                    state_next = st_respond;
                end else if (status.valid[victim_c] && status.dirty[victim_c]) begin
                    state_next = st_writeback;
                end else begin
                    state_next = st_fill;
                end
            end
            st_respond:   state_next = st_idle;    // request drops during this cycle.
            st_writeback: if (pmem_resp) state_next = st_fill;
            st_fill:      if (pmem_resp) state_next = st_lookup;
            default:      state_next = st_idle;
        endcase
    end

    ////////////////////
    // outputs
    ////////////////////
    assign mem_resp   = (state == st_compare) && hit_any;
    assign pmem_write = (state == st_writeback);
    assign pmem_read  = (state == st_fill);

    always_comb begin
        ctrl               = '0;
        ctrl.valid_in      = 1'b1;
        ctrl.victim_way    = victim_q;
        ctrl.out_way       = status.hit_way;
        ctrl.data_in_sel   = l2_cache_pkg::data_in_cpu;
        ctrl.pmem_addr_sel = (state == st_writeback) ? l2_cache_pkg::pmem_addr_wb
                                                     : l2_cache_pkg::pmem_addr_fill;
        if (state == st_compare && hit_any && mem_write) begin
            ctrl.tag_load  = status.hit;    // write hit marks the line dirty.
            ctrl.data_load = status.hit;
            ctrl.dirty_in  = 1'b1;
        end else if (state == st_fill && pmem_resp) begin
            ctrl.tag_load    = l2_cache_pkg::way_vec_t'(4'b0001 << victim_q);
            ctrl.data_load   = l2_cache_pkg::way_vec_t'(4'b0001 << victim_q);
            ctrl.dirty_in    = 1'b0;    // a fresh line matches memory.
            ctrl.data_in_sel = l2_cache_pkg::data_in_mem;
        end
    end

endmodule

// File: src/l2_cache.sv
// L2 cache top.
// Joins the controller and the datapath between the CPU-side and
// memory-side line ports.

module l2_cache (
    input  logic                clk,
    input  logic                rst_n,

    // cpu side.
    input  logic [31:0]         mem_address,
    output l2_cache_pkg::line_t mem_rdata256,
    input  l2_cache_pkg::line_t mem_wdata256,
    input  logic                mem_read,
    input  logic                mem_write,
    output logic                mem_resp,

    // memory side.
    output logic [31:0]         pmem_address,
    input  l2_cache_pkg::line_t pmem_rdata,
    output l2_cache_pkg::line_t pmem_wdata,
    output logic                pmem_read,
    output logic                pmem_write,
    input  logic                pmem_resp
);

    l2_cache_pkg::dp_ctrl_t   ctrl;
    l2_cache_pkg::dp_status_t status;

    l2_cache_control control_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_address (mem_address),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_resp    (mem_resp),
        .pmem_read   (pmem_read),
        .pmem_write  (pmem_write),
        .pmem_resp   (pmem_resp),
        .status      (status),
        .ctrl        (ctrl)
    );

    l2_cache_datapath datapath_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_address  (mem_address),
        .mem_wdata256 (mem_wdata256),
        .mem_rdata256 (mem_rdata256),
        .pmem_rdata   (pmem_rdata),
        .pmem_wdata   (pmem_wdata),
        .pmem_address (pmem_address),
        .ctrl         (ctrl),
        .status       (status)
    );

endmodule

// File: bench/pmem_model.sv
// Physical memory model for the L2 cache testbench.
// Whole-line reads and writes answered after a fixed latency, with
// read and write counts and a record of the last accesses.

module pmem_model (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [31:0]         pmem_address,
    input  logic                pmem_read,
    input  logic                pmem_write,
    input  l2_cache_pkg::line_t pmem_wdata,
    output l2_cache_pkg::line_t pmem_rdata,
    output logic                pmem_resp,
    output int                  read_count,
    output int                  write_count,
    output logic [31:0]         last_read_addr,
    output logic [31:0]         last_write_addr,
    output l2_cache_pkg::line_t last_write_data
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int latency = 4;

    l2_cache_pkg::line_t lines [logic [26:0]];    // only lines that were written live here.
    logic [26:0]         key;
    int                  wait_cnt;

    assign key = pmem_address[31:5];

    // unwritten lines read back a pattern built from the line address.
    function automatic l2_cache_pkg::line_t fill_pattern(input logic [31:0] addr);
        l2_cache_pkg::line_t line;
        for (int k = 0; k < 8; k++) begin
            line[k*32 +: 32] = {addr[31:5], 5'(k)} ^ 32'h3c96a5f0;
        end
        return line;
    endfunction

    ////////////////////
    // request handling
    ////////////////////
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pmem_resp       <= 1'b0;
            pmem_rdata      <= '0;
            wait_cnt        <= 0;
            read_count      <= 0;
            write_count     <= 0;
            last_read_addr  <= '0;
            last_write_addr <= '0;
            last_write_data <= '0;
        end else begin
            pmem_resp <= 1'b0;
            if ((pmem_read || pmem_write) && !pmem_resp) begin
                if (wait_cnt == latency - 1) begin
                    wait_cnt  <= 0;
                    pmem_resp <= 1'b1;    // a one-cycle pulse that ends the request.
                    if (pmem_write) begin
                        lines[key] = pmem_wdata;
                        write_count     <= write_count + 1;
                        last_write_addr <= pmem_address;
                        last_write_data <= pmem_wdata;
                    end else begin
                        pmem_rdata     <= lines.exists(key) ? lines[key]
                                                            : fill_pattern(pmem_address);
                        read_count     <= read_count + 1;
                        last_read_addr <= pmem_address;
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end else begin
                wait_cnt <= 0;
            end
        end
    end

endmodule

// File: bench/l2_cache_tb.sv
// L2 cache testbench.
// Directed tests for read and write hits, clean and dirty misses and
// write allocate, run against a line memory model.

module l2_cache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int resp_timeout = 200;

    logic                clk;
    logic                rst_n;
    logic [31:0]         mem_address;
    l2_cache_pkg::line_t mem_rdata256;
    l2_cache_pkg::line_t mem_wdata256;
    logic                mem_read;
    logic                mem_write;
    logic                mem_resp;
    logic [31:0]         pmem_address;
    l2_cache_pkg::line_t pmem_rdata;
    l2_cache_pkg::line_t pmem_wdata;
    logic                pmem_read;
    logic                pmem_write;
    logic                pmem_resp;
    int                  read_count;
    int                  write_count;
    logic [31:0]         last_read_addr;
    logic [31:0]         last_write_addr;
    l2_cache_pkg::line_t last_write_data;
    l2_cache_pkg::line_t data_a;    // line written to set 1 and later evicted.
    int                  seed = 32'h10c27dcc;

    l2_cache dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_address  (mem_address),
        .mem_rdata256 (mem_rdata256),
        .mem_wdata256 (mem_wdata256),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_resp     (mem_resp),
        .pmem_address (pmem_address),
        .pmem_rdata   (pmem_rdata),
        .pmem_wdata   (pmem_wdata),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_resp    (pmem_resp)
    );

    pmem_model pmem_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .pmem_address    (pmem_address),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_wdata      (pmem_wdata),
        .pmem_rdata      (pmem_rdata),
        .pmem_resp       (pmem_resp),
        .read_count      (read_count),
        .write_count     (write_count),
        .last_read_addr  (last_read_addr),
        .last_write_addr (last_write_addr),
        .last_write_data (last_write_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////
    function automatic logic [31:0] line_addr(input l2_cache_pkg::tag_t tag,
                                              input logic [l2_cache_pkg::s_index-1:0] index);
        return {tag, index, {l2_cache_pkg::s_offset{1'b0}}};
    endfunction

    // the memory fills each 32-bit word with its line address and word number.
    function automatic l2_cache_pkg::line_t expected_fill_line(input logic [31:0] addr);
        l2_cache_pkg::line_t line;
        for (int k = 0; k < 8; k++) begin
            line[k*32 +: 32] = {addr[31:5], 5'(k)} ^ 32'h3c96a5f0;
        end
        return line;
    endfunction

    function automatic l2_cache_pkg::line_t random_line();
        l2_cache_pkg::line_t line;
        for (int k = 0; k < 8; k++) begin
            line[k*32 +: 32] = $random(seed);
        end
        return line;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_line(input string name, input l2_cache_pkg::line_t expected,
                              input l2_cache_pkg::line_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected 0x%h, actual 0x%h", name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected %0d (0x%08h), actual %0d (0x%08h)",
                                name, expected, expected, actual, actual));
        end
    endtask

    // one request on the cpu side, held until mem_resp and dropped on the next edge.
    task automatic cpu_access(input string name, input logic [31:0] addr, input logic is_write,
                              input l2_cache_pkg::line_t wdata,
                              output l2_cache_pkg::line_t rdata, output int edges);
        logic seen;
        seen  = 1'b0;
        edges = 0;
        @(posedge clk);
        mem_address  <= addr;
        mem_wdata256 <= wdata;
        mem_read     <= !is_write;
        mem_write    <= is_write;
        while (!seen && edges < resp_timeout) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            seen = mem_resp;
        end
        if (!seen) begin
            abort_run($sformatf("%s: no mem_resp within %0d cycles", name, resp_timeout));
        end
        rdata = mem_rdata256;
        @(posedge clk);
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
    endtask

    ////////////////////
    // tests
    ////////////////////
    task automatic test_read_miss();
        l2_cache_pkg::line_t rdata;
        int                  edges;
        logic [31:0]         addr;
        addr = line_addr(24'h000010, 3'd1);
        check_count("reset mem_resp", 0, int'(mem_resp));
        check_count("reset pmem_read", 0, int'(pmem_read));
        check_count("reset pmem_write", 0, int'(pmem_write));
        cpu_access("read_miss", addr, 1'b0, '0, rdata, edges);
        check_line("read_miss data", expected_fill_line(addr), rdata);
        check_count("read_miss pmem reads", 1, read_count);
        check_count("read_miss pmem writes", 0, write_count);
        check_count("read_miss pmem address", addr, last_read_addr);
    endtask

    task automatic test_read_hit();
        l2_cache_pkg::line_t rdata;
        int                  edges;
        logic [31:0]         addr;
        addr = line_addr(24'h000010, 3'd1);
        cpu_access("read_hit", addr, 1'b0, '0, rdata, edges);
        check_line("read_hit data", expected_fill_line(addr), rdata);
        check_count("read_hit latency", 2, edges);    // array read edge, then compare edge.
        check_count("read_hit pmem reads", 1, read_count);
        check_count("read_hit pmem writes", 0, write_count);
    endtask

    task automatic test_write_hit();
        l2_cache_pkg::line_t rdata;
        int                  edges;
        logic [31:0]         addr;
        addr   = line_addr(24'h000010, 3'd1);
        data_a = random_line();
        cpu_access("write_hit", addr, 1'b1, data_a, rdata, edges);
        cpu_access("write_hit readback", addr, 1'b0, '0, rdata, edges);
        check_line("write_hit readback data", data_a, rdata);
        check_count("write_hit pmem reads", 1, read_count);
        check_count("write_hit pmem writes", 0, write_count);
    endtask

    task automatic test_dirty_eviction();
        l2_cache_pkg::line_t rdata;
        int                  edges;
        int                  reads_before;
        int                  writes_before;
        logic [31:0]         addr_e;
        addr_e = line_addr(24'h000014, 3'd1);
        // set 1 has tag 10 in way 0, dirty, and the tree reads 011.
        cpu_access("evict fill b", line_addr(24'h000011, 3'd1), 1'b0, '0, rdata, edges);
        cpu_access("evict fill c", line_addr(24'h000012, 3'd1), 1'b1, random_line(),
                   rdata, edges);
        cpu_access("evict fill d", line_addr(24'h000013, 3'd1), 1'b0, '0, rdata, edges);
        // ways 1, 2 and 3 filled in turn leave the tree at 000, which points at way 0.
        reads_before  = read_count;
        writes_before = write_count;
        cpu_access("evict e", addr_e, 1'b0, '0, rdata, edges);
        check_count("evict pmem writes", writes_before + 1, write_count);
        check_count("evict writeback address", line_addr(24'h000010, 3'd1), last_write_addr);
        check_line("evict writeback data", data_a, last_write_data);
        check_count("evict pmem reads", reads_before + 1, read_count);
        check_count("evict fill address", addr_e, last_read_addr);
        check_line("evict e data", expected_fill_line(addr_e), rdata);
    endtask

    task automatic test_write_allocate();
        l2_cache_pkg::line_t rdata;
        l2_cache_pkg::line_t data_f;
        int                  edges;
        int                  reads_before;
        int                  writes_before;
        logic [31:0]         addr_f;
        addr_f        = line_addr(24'h000020, 3'd5);
        data_f        = random_line();
        reads_before  = read_count;
        writes_before = write_count;
        cpu_access("alloc write", addr_f, 1'b1, data_f, rdata, edges);
        check_count("alloc fill reads", reads_before + 1, read_count);
        check_count("alloc fill address", addr_f, last_read_addr);
        check_count("alloc pmem writes", writes_before, write_count);
        cpu_access("alloc readback", addr_f, 1'b0, '0, rdata, edges);
        check_line("alloc readback data", data_f, rdata);
        check_count("alloc readback reads", reads_before + 1, read_count);
        // three more tags fill ways 1 to 3, so the fourth one evicts way 0.
        for (int t = 1; t <= 4; t++) begin
            writes_before = write_count;
            cpu_access("alloc evict", line_addr(24'(32'h20 + t), 3'd5), 1'b0, '0, rdata, edges);
        end
        check_count("alloc evict writes", writes_before + 1, write_count);
        check_count("alloc evict address", addr_f, last_write_addr);
        check_line("alloc evict data", data_f, last_write_data);
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        rst_n        <= 1'b0;
        mem_address  <= '0;
        mem_wdata256 <= '0;
        mem_read     <= 1'b0;
        mem_write    <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_read_miss();
        test_read_hit();
        test_write_hit();
        test_dirty_eviction();
        test_write_allocate();
        $display("No errors");
        $finish;
    end

endmodule

// File: flist.f
src/l2_cache_pkg.sv
src/l2_set_array.sv
src/l2_cache_datapath.sv
src/l2_cache_control.sv
src/l2_cache.sv
bench/pmem_model.sv
bench/l2_cache_tb.sv

// File: Makefile
# Verilator flow for the L2 cache testbench.
# Every variable below can be overridden on the make command line.

VERILATOR ?= verilator
TOP       ?= l2_cache_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --timescale $(TIMESCALE)
PASS_MSG  ?= No errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
